// ==== bulk_telemetry.f ====
+incdir+.
telemetry_pkg.sv
stream_pkg.sv
telemetry_capture.sv
telemetry_fifo.sv
stream_narrower.sv
bulk_telemetry.sv
tb_bulk_telemetry.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_bulk_telemetry

.PHONY: run clean

run: $(SIM) bulk_telemetry_patterns.txt
	./$(SIM) | tee sim.log
	grep -q "^Regression passed$$" sim.log

$(SIM): bulk_telemetry.f bulk_telemetry_consts.svh telemetry_pkg.sv stream_pkg.sv \
        telemetry_capture.sv telemetry_fifo.sv stream_narrower.sv bulk_telemetry.sv \
        tb_bulk_telemetry.sv
	verilator --binary --timing --assert --top-module tb_bulk_telemetry \
	  -f bulk_telemetry.f -o Vtb_bulk_telemetry

clean:
	rm -rf obj_dir sim.log

// ==== bulk_telemetry_patterns.txt ====
# status (hex: crc usb ctl blk) lo_byte lo_last hi_byte hi_last
# Each status makes one word sent low byte first, hi_last marks every eighth word
# Frame 1
01000 00 0 10 0
02000 00 0 20 0
02101 01 0 21 0
12101 01 0 21 0
02101 01 0 21 0
03240 40 0 32 0
03381 81 0 33 0
035a5 a5 0 35 1
# Frame 2
0355a 5a 0 35 0
1366c 6c 0 36 0
03700 00 0 37 0
038ff ff 0 38 0
09f3c 3c 0 9f 0
0a0c3 c3 0 a0 0
1a0c3 c3 0 a0 0
0f7e1 e1 0 f7 1

// ==== tb_bulk_telemetry.sv ====
`include "bulk_telemetry_consts.svh"

module tb_bulk_telemetry;

  localparam int WORDS      = 16;
  localparam int WAIT_LIMIT = 4000;

  logic                         clock;
  logic                         reset;
  logic                         usb_enum_i;
  telemetry_pkg::usb_status_t   status_i;
  logic                         select_i;
  logic                         start_i;
  logic [3:0]                   endpt_i;
  logic                         error_o;
  logic [`TELEM_LEVEL_BITS-1:0] level_o;
  logic                         s_tvalid_i;
  logic                         s_tlast_i;
  logic [7:0]                   s_tdata_i;
  logic                         s_tready_o;
  logic                         m_tvalid_o;
  logic                         m_tlast_o;
  logic [7:0]                   m_tdata_o;
  logic                         m_tready_i;

  telemetry_pkg::usb_status_t   pattern_status [WORDS];
  stream_pkg::byte_beat_t       pattern_beats [2*WORDS];
  int                           value_errors;
  int                           other_errors;

  bulk_telemetry u_dut (.*);

  always #2 clock = ~clock;

  task automatic expect_equal(input int actual, input int expected, input string what);
    assert (actual == expected) else begin
      $display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      value_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    other_errors++;
  endtask

  task automatic load_patterns();
    int          fd;
    int          count;
    string       line;
    logic [16:0] status;
    logic [7:0]  lo_data;
    logic [7:0]  hi_data;
    logic        lo_last;
    logic        hi_last;
    count = 0;
    fd = $fopen("bulk_telemetry_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open bulk_telemetry_patterns.txt");
      other_errors++;
    end else begin
      while (!$feof(fd) && count < WORDS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#" &&
            $sscanf(line, "%h %h %b %h %b", status, lo_data, lo_last, hi_data, hi_last) == 5) begin
          pattern_status[count]    = status;
          pattern_beats[2*count]   = {lo_last, lo_data};
          pattern_beats[2*count+1] = {hi_last, hi_data};
          // blk_state is the low byte, usb and ctl state the high byte
          expect_equal(int'({lo_last, lo_data}), int'({1'b0, status[7:0]}),
                       $sformatf("file low byte of word %0d", count));
          expect_equal(int'({hi_last, hi_data}),
                       int'({(count % `TELEM_FRAME_WORDS) == `TELEM_FRAME_WORDS - 1,
                             status[15:8]}),
                       $sformatf("file high byte of word %0d", count));
          count++;
        end
      end
      $fclose(fd);
    end
    assert (count == WORDS) else begin
      $display("Patterns file holds %0d status lines instead of %0d", count, WORDS);
      other_errors++;
    end
  endtask

  // Held two cycles so each value makes one change
  task automatic apply_status(input telemetry_pkg::usb_status_t value);
    @(posedge clock);
    status_i <= value;
    @(posedge clock);
  endtask

  task automatic wait_for_level(input int expected);
    int waited;
    waited = 0;
    @(negedge clock);
    while (int'(level_o) != expected && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    assert (waited < WAIT_LIMIT) else
      report_timeout($sformatf("level_o to reach %0d", expected));
  endtask

  task automatic expect_idle(input int cycles, input int level);
    repeat (cycles) begin
      @(negedge clock);
      expect_equal(int'(m_tvalid_o), 0, "m_tvalid_o while idle");
      expect_equal(int'(m_tlast_o), 0, "m_tlast_o while idle");
      expect_equal(int'(m_tdata_o), 0, "m_tdata_o while idle");
      expect_equal(int'(s_tready_o), 0, "s_tready_o while idle");
      expect_equal(int'(level_o), level, "level_o while idle");
    end
  endtask

  task automatic start_transfer(input logic [3:0] endpoint, input logic select);
    @(posedge clock);
    start_i  <= 1'b1;
    select_i <= select;
    endpt_i  <= endpoint;
    @(posedge clock);
    start_i  <= 1'b0;
    select_i <= 1'b0;
  endtask

  // Reads one frame with random gaps in m_tready_i and junk OUT bytes
  task automatic read_frame(input int first);
    int got;
    int waited;
    got = 0;
    waited = 0;
    start_transfer(`TELEM_ENDPOINT, 1'b1);
    while (got < 2*`TELEM_FRAME_WORDS && waited < WAIT_LIMIT) begin
      m_tready_i <= ($urandom % 4) != 0;
      s_tvalid_i <= ($urandom % 2) != 0;
      s_tlast_i  <= ($urandom % 8) == 0;
      s_tdata_i  <= 8'($urandom);
      @(negedge clock);
      expect_equal(int'(s_tready_o), 1, "s_tready_o while selected");
      if (m_tvalid_o && m_tready_i) begin
        expect_equal(int'({m_tlast_o, m_tdata_o}), int'(pattern_beats[first + got]),
                     $sformatf("beat %0d as {last, data}", first + got));
        got++;
      end
      waited++;
      @(posedge clock);
    end
    m_tready_i <= 1'b0;
    s_tvalid_i <= 1'b0;
    assert (got == 2*`TELEM_FRAME_WORDS) else
      report_timeout($sformatf("frame bytes from beat %0d", first));
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    usb_enum_i   = 1'b0;
    status_i     = '0;
    select_i     = 1'b0;
    start_i      = 1'b0;
    endpt_i      = 4'd0;
    s_tvalid_i   = 1'b0;
    s_tlast_i    = 1'b0;
    s_tdata_i    = 8'h00;
    m_tready_i   = 1'b0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'hb37d));
    load_patterns();

    repeat (4) @(posedge clock);
    reset      <= 1'b0;
    usb_enum_i <= 1'b1;
    expect_idle(2, 0);

    // Nothing leaves the FIFO while the endpoint is idle
    for (int i = 0; i < WORDS; i++) begin
      apply_status(pattern_status[i]);
    end
    wait_for_level(WORDS);
    expect_idle(8, WORDS);

    start_transfer(`TELEM_ENDPOINT + 4'd1, 1'b1);
    expect_idle(6, WORDS);
    start_transfer(`TELEM_ENDPOINT, 1'b0);
    expect_idle(6, WORDS);

    read_frame(0);
    wait_for_level(WORDS - `TELEM_FRAME_WORDS);
    expect_idle(4, WORDS - `TELEM_FRAME_WORDS);

    // Changes while not enumerated
    @(posedge clock);
    usb_enum_i <= 1'b0;
    repeat (6) apply_status(17'($urandom));
    @(posedge clock);
    usb_enum_i <= 1'b1;
    expect_idle(6, WORDS - `TELEM_FRAME_WORDS);

    read_frame(2*`TELEM_FRAME_WORDS);
    wait_for_level(0);
    expect_idle(4, 0);
    expect_equal(int'(error_o), 0, "error_o before overflow");

    // A change every cycle with no reader
    repeat (`TELEM_FIFO_DEPTH + 16) begin
      @(posedge clock);
      status_i <= status_i + 17'd1;
    end
    wait_for_level(`TELEM_FIFO_DEPTH);
    repeat (8) begin
      @(negedge clock);
      expect_equal(int'(error_o), 1, "error_o after overflow");
      expect_equal(int'(level_o), `TELEM_FIFO_DEPTH, "level_o while full");
    end

    @(posedge clock);
    usb_enum_i <= 1'b0;
    reset      <= 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    expect_equal(int'(error_o), 0, "error_o after reset");
    expect_idle(2, 0);

    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== bulk_telemetry.sv ====
`include "bulk_telemetry_consts.svh"

module bulk_telemetry #(
  parameter logic [3:0] endpoint = `TELEM_ENDPOINT
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         usb_enum_i,
  input  telemetry_pkg::usb_status_t   status_i,
  input  logic                         select_i,
  input  logic                         start_i,
  input  logic [3:0]                   endpt_i,
  output logic                         error_o,
  output logic [`TELEM_LEVEL_BITS-1:0] level_o,
  input  logic                         s_tvalid_i,
  input  logic                         s_tlast_i,
  input  logic [7:0]                   s_tdata_i,
  output logic                         s_tready_o,
  output logic                         m_tvalid_o,
  output logic                         m_tlast_o,
  output logic [7:0]                   m_tdata_o,
  input  logic                         m_tready_i
);

  logic                        sel_q;
  logic                        push;
  logic                        full;
  telemetry_pkg::telem_entry_t push_entry;
  telemetry_pkg::telem_entry_t head_entry;
  logic                        head_valid;
  logic                        pop;
  stream_pkg::byte_beat_t      out_beat;
  logic                        out_valid;
  logic                        out_ready;

  telemetry_capture u_capture (
    .clock      (clock),
    .reset      (reset),
    .enum_i     (usb_enum_i),
    .status_i   (status_i),
    .full_i     (full),
    .push_o     (push),
    .entry_o    (push_entry),
    .overflow_o (error_o)
  );

  telemetry_fifo u_fifo (
    .clock   (clock),
    .reset   (reset),
    .push_i  (push),
    .entry_i (push_entry),
    .full_o  (full),
    .pop_i   (pop),
    .valid_o (head_valid),
    .entry_o (head_entry),
    .level_o (level_o)
  );

  stream_narrower u_narrower (
    .clock   (clock),
    .reset   (reset),
    .valid_i (head_valid),
    .entry_i (head_entry),
    .pop_o   (pop),
    .valid_o (out_valid),
    .beat_o  (out_beat),
    .ready_i (out_ready)
  );

  // OUT bytes are taken while selected and dropped
  assign s_tready_o = sel_q;

  assign m_tvalid_o = sel_q && out_valid;
  assign out_ready  = sel_q && m_tready_i;
  assign m_tlast_o  = sel_q ? out_beat.last : 1'b0;
  assign m_tdata_o  = sel_q ? out_beat.data : 8'h00;

  // Selected from start until the frame end byte is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (start_i && select_i && endpt_i == endpoint) begin
      sel_q <= 1'b1;
    end else if (m_tvalid_o && m_tready_i && m_tlast_o) begin
      sel_q <= 1'b0;
    end
  end

  a_out_known: assert property (@(posedge clock) disable iff (reset)
    (s_tvalid_i && s_tready_o) |-> !$isunknown({s_tlast_i, s_tdata_i}));

endmodule

// ==== stream_narrower.sv ====
module stream_narrower (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        valid_i,
  input  telemetry_pkg::telem_entry_t entry_i,
  output logic                        pop_o,
  output logic                        valid_o,
  output stream_pkg::byte_beat_t      beat_o,
  input  logic                        ready_i
);

  telemetry_pkg::telem_entry_t entry_q;
  logic                        loaded_q;
  logic                        half_q;
  logic                        xfer;

  assign xfer    = loaded_q && ready_i;
  assign valid_o = loaded_q;

  // Take a new entry only while empty and the stream is open
  assign pop_o = valid_i && ready_i && !loaded_q;

  // Low byte first, frame end rides on the high byte
  always_comb begin
    if (half_q) begin
      beat_o.last = entry_q.last;
      beat_o.data = entry_q.word[15:8];
    end else begin
      beat_o.last = 1'b0;
      beat_o.data = entry_q.word[7:0];
    end
  end

  always_ff @(posedge clock) begin
    if (pop_o) begin
      entry_q <= entry_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      loaded_q <= 1'b0;
      half_q   <= 1'b0;
    end else if (pop_o) begin
      loaded_q <= 1'b1;
      half_q   <= 1'b0;
    end else if (xfer) begin
      half_q   <= !half_q;
      loaded_q <= !half_q;
    end
  end

  a_hold_beat: assert property (@(posedge clock) disable iff (reset)
    (valid_o && !ready_i) |=> valid_o && $stable(beat_o));

endmodule

// ==== telemetry_fifo.sv ====
`include "bulk_telemetry_consts.svh"

module telemetry_fifo (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          push_i,
  input  telemetry_pkg::telem_entry_t   entry_i,
  output logic                          full_o,
  input  logic                          pop_i,
  output logic                          valid_o,
  output telemetry_pkg::telem_entry_t   entry_o,
  output logic [`TELEM_LEVEL_BITS-1:0]  level_o
);

  localparam int AW = $clog2(`TELEM_FIFO_DEPTH);
  localparam logic [`TELEM_LEVEL_BITS-1:0] DEPTH_LEVEL = `TELEM_FIFO_DEPTH;

  telemetry_pkg::telem_entry_t mem [`TELEM_FIFO_DEPTH];
  telemetry_pkg::telem_entry_t head_q;
  logic                        head_valid_q;
  logic [AW-1:0]               wr_ptr_q;
  logic [AW-1:0]               rd_ptr_q;
  logic [`TELEM_LEVEL_BITS-1:0] level_q;
  logic                        wr_en;
  logic                        rd_en;
  logic                        pop_ok;
  logic                        mem_empty;

  assign full_o  = (level_q == DEPTH_LEVEL);
  assign valid_o = head_valid_q;
  assign entry_o = head_q;
  assign level_o = level_q;

  assign wr_en  = push_i && !full_o;
  assign pop_ok = pop_i && head_valid_q;

  // Entries held in memory, the head register excluded
  assign mem_empty = (level_q == {{(`TELEM_LEVEL_BITS-1){1'b0}}, head_valid_q});

  // Refill the head when it is empty or leaving this cycle
  assign rd_en = !mem_empty && (!head_valid_q || pop_ok);

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= entry_i;
    end
    if (rd_en) begin
      head_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      head_valid_q <= 1'b0;
      level_q      <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q     <= rd_ptr_q + 1'b1;
        head_valid_q <= 1'b1;
      end else if (pop_ok) begin
        head_valid_q <= 1'b0;
      end
      if (wr_en && !pop_ok) begin
        level_q <= level_q + 1'b1;
      end else if (pop_ok && !wr_en) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // The consumer only pops a presented head
  a_pop_valid: assert property (@(posedge clock) disable iff (reset)
    pop_i |-> valid_o);

  a_level_max: assert property (@(posedge clock) disable iff (reset)
    level_q <= DEPTH_LEVEL);

endmodule

// ==== telemetry_capture.sv ====
`include "bulk_telemetry_consts.svh"

module telemetry_capture (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        enum_i,
  input  telemetry_pkg::usb_status_t  status_i,
  input  logic                        full_i,
  output logic                        push_o,
  output telemetry_pkg::telem_entry_t entry_o,
  output logic                        overflow_o
);

  telemetry_pkg::usb_status_t prev_q;
  logic                       changed;
  logic                       last;
  logic [2:0]                 count_q;
  logic                       overflow_q;

  // Any field counts, the CRC flag included
  assign changed = enum_i && (status_i != prev_q);
  assign push_o  = changed && !full_i;
  assign last    = (count_q == 3'(`TELEM_FRAME_WORDS - 1));

  always_comb begin
    entry_o                = '0;
    entry_o.last           = last;
    entry_o.word.usb_state = status_i.usb_state;
    entry_o.word.ctl_state = status_i.ctl_state;
    entry_o.word.blk_state = status_i.blk_state;
  end

  assign overflow_o = overflow_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      prev_q     <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      prev_q <= status_i;
      // Wraps to zero after the frame end word
      if (push_o) begin
        count_q <= count_q + 3'd1;
      end
      // Sticky until reset
      if (changed && full_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // A status held after a push makes no second word
  a_one_word: assert property (@(posedge clock) disable iff (reset)
    (push_o ##1 $stable(status_i)) |-> !push_o);

  // Frames restart only after the word marked last
  a_frame_wrap: assert property (@(posedge clock) disable iff (reset)
    (count_q == 3'd0 && $past(count_q) != 3'd0) |-> $past(push_o && last));

endmodule

// ==== stream_pkg.sv ====
package stream_pkg;

  // One byte on the bulk IN stream
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } byte_beat_t;

endpackage

// ==== telemetry_pkg.sv ====
package telemetry_pkg;

  // Live or sampled device status as seen from the USB core
  typedef struct packed {
    logic       crc_error;
    logic [3:0] usb_state;
    logic [3:0] ctl_state;
    logic [7:0] blk_state;
  } usb_status_t;

  // Stored telemetry word, CRC flag not kept
  typedef struct packed {
    logic [3:0] usb_state;
    logic [3:0] ctl_state;
    logic [7:0] blk_state;
  } telem_word_t;

  // One FIFO entry
  typedef struct packed {
    logic        last;
    telem_word_t word;
  } telem_entry_t;

endpackage

// ==== bulk_telemetry_consts.svh ====
`ifndef BULK_TELEMETRY_CONSTS_SVH
`define BULK_TELEMETRY_CONSTS_SVH

// Telemetry words per frame, the last one carries the frame end
`define TELEM_FRAME_WORDS 8

// Telemetry FIFO depth in entries
`define TELEM_FIFO_DEPTH 512

// Fill level width, wide enough to count a full FIFO
`define TELEM_LEVEL_BITS 10

// Bulk IN endpoint served by default
`define TELEM_ENDPOINT 4'd2

`endif
